//--- hdl/flitPkg.sv
package flitPkg;

  // ====================
  // Flit format
  // ====================

  typedef enum logic [2:0]
  {
    flitIdle = 3'b000,
    flitHead = 3'b001,  // Hold limit sits in the low payload bits
    flitBody = 3'b010,
    flitTail = 3'b011
  } flitKindT;

  localparam int dataWidth = 16;  // Payload bits per flit
  localparam int lenWidth  = 12;  // Hold limit field of a head flit

  // ====================
  // Input buffering
  // ====================

  localparam int fifoDepth = 8;
  localparam int ptrWidth  = $clog2(fifoDepth);
  localparam int cntWidth  = $clog2(fifoDepth + 1);

endpackage

//--- hdl/arbPkg.sv
package arbPkg;

  localparam int numPorts = 5;

  // Input ports, listed in rotation order
  typedef enum logic [2:0]
  {
    portL = 3'd0,
    portN = 3'd1,
    portE = 3'd2,
    portW = 3'd3,
    portS = 3'd4
  } portT;

  // ====================
  // Arbiter states
  // ====================

  // One-hot, bit i+1 grants port i
  typedef enum logic [5:0]
  {
    stIdle   = 6'b000001,
    stGrantL = 6'b000010,
    stGrantN = 6'b000100,
    stGrantE = 6'b001000,
    stGrantW = 6'b010000,
    stGrantS = 6'b100000
  } arbStateT;

endpackage

//--- hdl/inputFifo.sv
module inputFifo
(
  input  logic                          clk,
  input  logic                          rst,
  input  flitPkg::flitKindT             inKind,
  input  logic [flitPkg::dataWidth-1:0] inData,
  input  logic                          inValid,
  output logic                          inReady,
  input  logic                          pop,
  output flitPkg::flitKindT             frontKind,
  output logic [flitPkg::dataWidth-1:0] frontData,
  output logic                          empty
);

  flitPkg::flitKindT             kindMem [flitPkg::fifoDepth];
  logic [flitPkg::dataWidth-1:0] dataMem [flitPkg::fifoDepth];
  logic [flitPkg::ptrWidth-1:0]  wrPtr;
  logic [flitPkg::ptrWidth-1:0]  rdPtr;
  logic [flitPkg::cntWidth-1:0]  count;
  logic                          push;

  assign inReady   = int'(count) != flitPkg::fifoDepth;  // Low only while full
  assign push      = inValid && inReady;
  assign empty     = count == '0;
  assign frontKind = kindMem[rdPtr];
  assign frontData = dataMem[rdPtr];

  // Flit storage
  always_ff @(posedge clk)
  begin
    if (push)
    begin
      kindMem[wrPtr] <= inKind;
      dataMem[wrPtr] <= inData;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (push)
        wrPtr <= wrPtr + 1'b1;  // Power-of-two depth, wraps by itself
      if (pop)
        rdPtr <= rdPtr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- hdl/holdTimer.sv
module holdTimer
(
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         headSent,
  input  logic [flitPkg::lenWidth-1:0] length,
  input  logic                         sent,
  input  logic                         granted,
  output logic                         timesUp
);

  logic [flitPkg::lenWidth-1:0] limit;
  logic [flitPkg::lenWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (headSent)
        limit <= length;
      if (!granted)
        count <= '0;  // New budget on every grant
      else if (sent)
        count <= count + 1'b1;
    end
  end

  // A grant always gets its first flit through
  // so an empty count never counts as expired
  assign timesUp = (count != '0) && (count == limit);

endmodule

//--- hdl/switchArbiter.sv
module switchArbiter
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic [arbPkg::numPorts-1:0]   empty,
  input  flitPkg::flitKindT             lFrontKind, nFrontKind, eFrontKind,
  input  flitPkg::flitKindT             wFrontKind, sFrontKind,
  input  logic [flitPkg::dataWidth-1:0] lFrontData, nFrontData, eFrontData,
  input  logic [flitPkg::dataWidth-1:0] wFrontData, sFrontData,
  input  logic                          accept,
  output logic [arbPkg::numPorts-1:0]   pop,
  output logic                          load,
  output arbPkg::portT                  grantPort
);

  arbPkg::arbStateT             state;
  arbPkg::arbStateT             nextState;
  logic [arbPkg::numPorts-1:0]  req;
  logic [arbPkg::numPorts-1:0]  grantVec;
  logic [arbPkg::numPorts-1:0]  keep;
  logic [arbPkg::numPorts-1:0]  timesUp;
  logic [arbPkg::numPorts-1:0]  headSent;
  flitPkg::flitKindT            frontKind [arbPkg::numPorts];
  logic [flitPkg::lenWidth-1:0] frontLen [arbPkg::numPorts];

  // First requesting port among count ports, starting at first
  function automatic arbPkg::arbStateT firstReq
  (
    input logic [arbPkg::numPorts-1:0] reqs,
    input int                          first,
    input int                          count
  );
    arbPkg::arbStateT pick;
    int               idx;
    pick = arbPkg::stIdle;
    for (int k = count - 1; k >= 0; k--)
    begin
      idx = (first + k) % arbPkg::numPorts;
      if (reqs[idx])
        pick = arbPkg::arbStateT'(6'b000010 << idx);
    end
    return pick;
  endfunction

  assign frontKind[arbPkg::portL] = lFrontKind;
  assign frontKind[arbPkg::portN] = nFrontKind;
  assign frontKind[arbPkg::portE] = eFrontKind;
  assign frontKind[arbPkg::portW] = wFrontKind;
  assign frontKind[arbPkg::portS] = sFrontKind;
  assign frontLen[arbPkg::portL]  = lFrontData[flitPkg::lenWidth-1:0];
  assign frontLen[arbPkg::portN]  = nFrontData[flitPkg::lenWidth-1:0];
  assign frontLen[arbPkg::portE]  = eFrontData[flitPkg::lenWidth-1:0];
  assign frontLen[arbPkg::portW]  = wFrontData[flitPkg::lenWidth-1:0];
  assign frontLen[arbPkg::portS]  = sFrontData[flitPkg::lenWidth-1:0];

  // ====================
  // Transfer
  // ====================

  assign req      = ~empty;
  assign grantVec = state[5:1];
  assign keep     = grantVec & req & ~timesUp;  // Holder may go on
  assign pop      = accept ? keep : '0;
  assign load     = |pop;

  for (genvar i = 0; i < arbPkg::numPorts; i++)
  begin : genTimer
    assign headSent[i] = pop[i] && (frontKind[i] == flitPkg::flitHead);

    holdTimer holdTimer_i
    (
      .clk      (clk),
      .rst      (rst),
      .headSent (headSent[i]),
      .length   (frontLen[i]),
      .sent     (pop[i]),
      .granted  (grantVec[i]),
      .timesUp  (timesUp[i])
    );
  end

  // ====================
  // State machine
  // ====================

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= arbPkg::stIdle;
    else
      state <= nextState;
  end

  always_comb
  begin
    case (state)
      arbPkg::stGrantN: grantPort = arbPkg::portN;
      arbPkg::stGrantE: grantPort = arbPkg::portE;
      arbPkg::stGrantW: grantPort = arbPkg::portW;
      arbPkg::stGrantS: grantPort = arbPkg::portS;
      default:          grantPort = arbPkg::portL;
    endcase
  end

  always_comb
  begin
    case (state)
      arbPkg::stIdle:
        nextState = firstReq(req, 0, arbPkg::numPorts);  // Fixed priority L first
      arbPkg::stGrantL, arbPkg::stGrantN, arbPkg::stGrantE,
      arbPkg::stGrantW, arbPkg::stGrantS:
      begin
        if (|keep)
          nextState = state;
        else  // Rotate past the holder, holder excluded
          nextState = firstReq(req, int'(grantPort) + 1, arbPkg::numPorts - 1);
      end
      default:
        nextState = arbPkg::stIdle;
    endcase
  end

endmodule

//--- hdl/outputStage.sv
module outputStage
(
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          load,
  input  arbPkg::portT                  grantPort,
  input  flitPkg::flitKindT             lFrontKind, nFrontKind, eFrontKind,
  input  flitPkg::flitKindT             wFrontKind, sFrontKind,
  input  logic [flitPkg::dataWidth-1:0] lFrontData, nFrontData, eFrontData,
  input  logic [flitPkg::dataWidth-1:0] wFrontData, sFrontData,
  output flitPkg::flitKindT             outKind,
  output logic [flitPkg::dataWidth-1:0] outData,
  output arbPkg::portT                  outPort,
  output logic                          outValid,
  input  logic                          outReady,
  output logic                          accept
);

  flitPkg::flitKindT             selKind;
  logic [flitPkg::dataWidth-1:0] selData;

  // Crossbar column for this output
  always_comb
  begin
    case (grantPort)
      arbPkg::portN:
      begin
        selKind = nFrontKind;
        selData = nFrontData;
      end
      arbPkg::portE:
      begin
        selKind = eFrontKind;
        selData = eFrontData;
      end
      arbPkg::portW:
      begin
        selKind = wFrontKind;
        selData = wFrontData;
      end
      arbPkg::portS:
      begin
        selKind = sFrontKind;
        selData = sFrontData;
      end
      default:
      begin
        selKind = lFrontKind;
        selData = lFrontData;
      end
    endcase
  end

  assign accept = !outValid || outReady;  // Register free next cycle

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else if (load)
      outValid <= 1'b1;
    else if (outReady)
      outValid <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      outKind <= selKind;
      outData <= selData;
      outPort <= grantPort;
    end
  end

endmodule

//--- hdl/flitSwitch.sv
module flitSwitch
(
  input  logic                          clk,
  input  logic                          rst,
  input  flitPkg::flitKindT             lKind, nKind, eKind, wKind, sKind,
  input  logic [flitPkg::dataWidth-1:0] lData, nData, eData, wData, sData,
  input  logic                          lValid, nValid, eValid, wValid, sValid,
  output logic                          lReady, nReady, eReady, wReady, sReady,
  output flitPkg::flitKindT             outKind,
  output logic [flitPkg::dataWidth-1:0] outData,
  output arbPkg::portT                  outPort,
  output logic                          outValid,
  input  logic                          outReady
);

  flitPkg::flitKindT             lFrontKind, nFrontKind, eFrontKind, wFrontKind, sFrontKind;
  logic [flitPkg::dataWidth-1:0] lFrontData, nFrontData, eFrontData, wFrontData, sFrontData;
  logic [arbPkg::numPorts-1:0]   empty;
  logic [arbPkg::numPorts-1:0]   pop;
  logic                          accept;
  logic                          load;
  arbPkg::portT                  grantPort;

  // ====================
  // Input side
  // ====================

  inputFifo lFifo_i
  (
    .clk (clk), .rst (rst),
    .inKind (lKind), .inData (lData), .inValid (lValid), .inReady (lReady),
    .pop (pop[arbPkg::portL]), .empty (empty[arbPkg::portL]),
    .frontKind (lFrontKind), .frontData (lFrontData)
  );

  inputFifo nFifo_i
  (
    .clk (clk), .rst (rst),
    .inKind (nKind), .inData (nData), .inValid (nValid), .inReady (nReady),
    .pop (pop[arbPkg::portN]), .empty (empty[arbPkg::portN]),
    .frontKind (nFrontKind), .frontData (nFrontData)
  );

  inputFifo eFifo_i
  (
    .clk (clk), .rst (rst),
    .inKind (eKind), .inData (eData), .inValid (eValid), .inReady (eReady),
    .pop (pop[arbPkg::portE]), .empty (empty[arbPkg::portE]),
    .frontKind (eFrontKind), .frontData (eFrontData)
  );

  inputFifo wFifo_i
  (
    .clk (clk), .rst (rst),
    .inKind (wKind), .inData (wData), .inValid (wValid), .inReady (wReady),
    .pop (pop[arbPkg::portW]), .empty (empty[arbPkg::portW]),
    .frontKind (wFrontKind), .frontData (wFrontData)
  );

  inputFifo sFifo_i
  (
    .clk (clk), .rst (rst),
    .inKind (sKind), .inData (sData), .inValid (sValid), .inReady (sReady),
    .pop (pop[arbPkg::portS]), .empty (empty[arbPkg::portS]),
    .frontKind (sFrontKind), .frontData (sFrontData)
  );

  // ====================
  // Arbitration and output
  // ====================

  switchArbiter switchArbiter_i
  (
    .clk (clk), .rst (rst), .empty (empty),
    .lFrontKind (lFrontKind), .nFrontKind (nFrontKind), .eFrontKind (eFrontKind),
    .wFrontKind (wFrontKind), .sFrontKind (sFrontKind),
    .lFrontData (lFrontData), .nFrontData (nFrontData), .eFrontData (eFrontData),
    .wFrontData (wFrontData), .sFrontData (sFrontData),
    .accept (accept), .pop (pop), .load (load), .grantPort (grantPort)
  );

  outputStage outputStage_i
  (
    .clk (clk), .rst (rst), .load (load), .grantPort (grantPort),
    .lFrontKind (lFrontKind), .nFrontKind (nFrontKind), .eFrontKind (eFrontKind),
    .wFrontKind (wFrontKind), .sFrontKind (sFrontKind),
    .lFrontData (lFrontData), .nFrontData (nFrontData), .eFrontData (eFrontData),
    .wFrontData (wFrontData), .sFrontData (sFrontData),
    .outKind (outKind), .outData (outData), .outPort (outPort),
    .outValid (outValid), .outReady (outReady), .accept (accept)
  );

endmodule

//--- sim/flitSwitch_props.sv
module flitSwitchProps
(
  input logic                          clk,
  input logic                          rst,
  input logic [arbPkg::numPorts-1:0]   pop,
  input logic [arbPkg::numPorts-1:0]   empty,
  input logic                          outValid,
  input logic                          outReady,
  input flitPkg::flitKindT             outKind,
  input logic [flitPkg::dataWidth-1:0] outData,
  input arbPkg::portT                  outPort,
  input arbPkg::arbStateT              state
);

  noPopWhenEmpty: assert property (@(posedge clk) disable iff (rst) (pop & empty) == '0)
    else $error("pop raised on an empty FIFO");

  onePop: assert property (@(posedge clk) disable iff (rst) $onehot0(pop))
    else $error("more than one pop in a cycle");

  // Output holds until taken
  holdOutput: assert property (@(posedge clk) disable iff (rst)
    outValid && !outReady |=> outValid && $stable(outKind) && $stable(outData)
                              && $stable(outPort))
    else $error("output flit changed before it was taken");

  legalState: assert property (@(posedge clk) disable iff (rst)
    state inside {arbPkg::stIdle, arbPkg::stGrantL, arbPkg::stGrantN,
                  arbPkg::stGrantE, arbPkg::stGrantW, arbPkg::stGrantS})
    else $error("arbiter in an undefined state");

endmodule

bind flitSwitch flitSwitchProps flitSwitchProps_i
(
  .clk (clk), .rst (rst), .pop (pop), .empty (empty),
  .outValid (outValid), .outReady (outReady), .outKind (outKind),
  .outData (outData), .outPort (outPort), .state (switchArbiter_i.state)
);

//--- sim/flitSwitchTb.sv
module flitSwitchTb;

  logic                          clk;
  logic                          rst;
  flitPkg::flitKindT             kindDrv [arbPkg::numPorts];
  logic [flitPkg::dataWidth-1:0] dataDrv [arbPkg::numPorts];
  logic                          validDrv [arbPkg::numPorts];
  logic [arbPkg::numPorts-1:0]   readyVec;
  flitPkg::flitKindT             outKind;
  logic [flitPkg::dataWidth-1:0] outData;
  arbPkg::portT                  outPort;
  logic                          outValid;
  logic                          outReady;
  int                            readyMode;  // 0 low, 1 high, 2 random

  // Stimulus table
  int                            stTest [64];
  arbPkg::portT                  stPort [64];
  flitPkg::flitKindT             stKind [64];
  logic [flitPkg::dataWidth-1:0] stData [64];
  int                            tableLen = 0;

  flitPkg::flitKindT             expKind [$];
  logic [flitPkg::dataWidth-1:0] expData [$];
  arbPkg::portT                  expPort [$];
  flitPkg::flitKindT             rxKind [$];
  logic [flitPkg::dataWidth-1:0] rxData [$];
  arbPkg::portT                  rxPort [$];
  int                            modelLimit [arbPkg::numPorts];
  int                            accepted [arbPkg::numPorts];
  int                            stallCount = 0;
  int                            valueErrors = 0;
  int                            otherErrors = 0;

  flitSwitch flitSwitch_i
  (
    .clk (clk), .rst (rst),
    .lKind (kindDrv[0]), .nKind (kindDrv[1]), .eKind (kindDrv[2]),
    .wKind (kindDrv[3]), .sKind (kindDrv[4]),
    .lData (dataDrv[0]), .nData (dataDrv[1]), .eData (dataDrv[2]),
    .wData (dataDrv[3]), .sData (dataDrv[4]),
    .lValid (validDrv[0]), .nValid (validDrv[1]), .eValid (validDrv[2]),
    .wValid (validDrv[3]), .sValid (validDrv[4]),
    .lReady (readyVec[0]), .nReady (readyVec[1]), .eReady (readyVec[2]),
    .wReady (readyVec[3]), .sReady (readyVec[4]),
    .outKind (outKind), .outData (outData), .outPort (outPort),
    .outValid (outValid), .outReady (outReady)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk)
  begin
    case (readyMode)
      0:       outReady <= 1'b0;
      1:       outReady <= 1'b1;
      default: outReady <= 1'($urandom % 2);
    endcase
  end

  // Output monitor
  always @(posedge clk)
  begin
    if (!rst && outValid && outReady)
    begin
      rxKind.push_back(outKind);
      rxData.push_back(outData);
      rxPort.push_back(outPort);
    end
  end

  initial
  begin
    wait (tableLen > 0);
    repeat (tableLen * 40) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", tableLen * 40);
    $display("FAIL: see errors above");
    $finish;
  end

  // ====================
  // Compare tasks
  // ====================

  task automatic checkFlit(input flitPkg::flitKindT gotKind,
                           input logic [flitPkg::dataWidth-1:0] gotData,
                           input flitPkg::flitKindT wantKind,
                           input logic [flitPkg::dataWidth-1:0] wantData);
    if (gotKind !== wantKind)
    begin
      $display("FAILED t=%0t outKind got %s expected %s", $time, gotKind.name(),
               wantKind.name());
      valueErrors++;
    end
    if (gotData !== wantData)
    begin
      $display("FAILED t=%0t outData got %h expected %h", $time, gotData, wantData);
      valueErrors++;
    end
  endtask

  task automatic checkPort(input arbPkg::portT got, input arbPkg::portT want);
    if (got !== want)
    begin
      $display("FAILED t=%0t outPort got %s expected %s", $time, got.name(), want.name());
      valueErrors++;
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic want);
    if (got !== want)
    begin
      $display("FAILED t=%0t %s got %b expected %b", $time, name, got, want);
      valueErrors++;
    end
  endtask

  // ====================
  // Table and model
  // ====================

  task automatic addPacket(input int test, input arbPkg::portT port, input int len,
                           input int limit);
    for (int i = 0; i < len; i++)
    begin
      stTest[tableLen] = test;
      stPort[tableLen] = port;
      if (i == 0)
      begin
        stKind[tableLen] = flitPkg::flitHead;
        stData[tableLen] = {4'(test), 12'(limit)};  // Hold limit in low bits
      end
      else
      begin
        stKind[tableLen] = (i == len - 1) ? flitPkg::flitTail : flitPkg::flitBody;
        stData[tableLen] = 16'(test * 256 + int'(port) * 32 + i);
      end
      tableLen++;
    end
  endtask

  // Expected order: fixed priority from idle, then rotation past the holder
  task automatic buildExpected(input int test);
    int idx [arbPkg::numPorts][64];
    int cnt [arbPkg::numPorts];
    int head [arbPkg::numPorts];
    int holder;
    int next;
    int sent;
    int left;
    int e;
    int p;
    left = 0;
    for (int i = 0; i < arbPkg::numPorts; i++)
    begin
      cnt[i] = 0;
      head[i] = 0;
    end
    for (int i = 0; i < tableLen; i++)
    begin
      if (stTest[i] == test)
      begin
        p = int'(stPort[i]);
        idx[p][cnt[p]] = i;
        cnt[p]++;
        left++;
      end
    end
    holder = -1;
    while (left > 0)
    begin
      if (holder < 0)
        for (int q = arbPkg::numPorts - 1; q >= 0; q--)
          if (head[q] < cnt[q])
            holder = q;
      sent = 0;
      // First flit of a grant always goes
      while (head[holder] < cnt[holder] && (sent == 0 || sent != modelLimit[holder]))
      begin
        e = idx[holder][head[holder]];
        head[holder]++;
        if (stKind[e] == flitPkg::flitHead)
          modelLimit[holder] = int'(stData[e][flitPkg::lenWidth-1:0]);
        expKind.push_back(stKind[e]);
        expData.push_back(stData[e]);
        expPort.push_back(stPort[e]);
        sent++;
        left--;
      end
      next = -1;
      for (int k = arbPkg::numPorts - 1; k >= 1; k--)
        if (head[(holder + k) % arbPkg::numPorts] < cnt[(holder + k) % arbPkg::numPorts])
          next = (holder + k) % arbPkg::numPorts;
      holder = next;
    end
  endtask

  // ====================
  // Stimulus
  // ====================

  task automatic sendFlit(input int e);
    int p;
    p = int'(stPort[e]);
    kindDrv[p]  <= stKind[e];
    dataDrv[p]  <= stData[e];
    validDrv[p] <= 1'b1;
    @(posedge clk);
    while (!readyVec[p])
    begin
      if (readyMode == 0)
      begin
        // Stalled while the output is held, so the FIFO must be full
        stallCount++;
        if (accepted[p] != flitPkg::fifoDepth)
        begin
          $display("Port %0d stalled after %0d flits instead of %0d", p, accepted[p],
                   flitPkg::fifoDepth);
          otherErrors++;
        end
        checkBit("outValid", outValid, 1'b1);
        if (rxKind.size() != 0)
        begin
          $display("Flits left the switch while outReady was low");
          otherErrors++;
        end
        readyMode <= 1;  // Free space
      end
      @(posedge clk);
    end
    accepted[p]++;
    validDrv[p] <= 1'b0;
  endtask

  task automatic runTest(input int test);
    buildExpected(test);
    for (int i = 0; i < arbPkg::numPorts; i++)
      accepted[i] = 0;
    stallCount = 0;
    for (int i = 0; i < tableLen; i++)
      if (stTest[i] == test)
        sendFlit(i);
    if (test == 5 && stallCount == 0)
    begin
      $display("Test 5 never saw an in-port Ready drop on a full FIFO");
      otherErrors++;
    end
    readyMode <= (test == 4) ? 2 : 1;
    while (rxKind.size() < expKind.size())
      @(posedge clk);
    repeat (5) @(posedge clk);
    if (rxKind.size() != expKind.size())
    begin
      $display("Test %0d received %0d flits, expected %0d", test, rxKind.size(),
               expKind.size());
      otherErrors++;
    end
    else
    begin
      for (int i = 0; i < expKind.size(); i++)
      begin
        checkFlit(rxKind[i], rxData[i], expKind[i], expData[i]);
        checkPort(rxPort[i], expPort[i]);
      end
    end
    expKind.delete();
    expData.delete();
    expPort.delete();
    rxKind.delete();
    rxData.delete();
    rxPort.delete();
    readyMode <= 0;
    repeat (2) @(posedge clk);
  endtask

  initial
  begin
    void'($urandom(96608));
    rst = 1'b1;
    outReady = 1'b0;
    readyMode = 0;
    for (int i = 0; i < arbPkg::numPorts; i++)
    begin
      kindDrv[i] = flitPkg::flitIdle;
      dataDrv[i] = '0;
      validDrv[i] = 1'b0;
      modelLimit[i] = 0;
    end
    addPacket(2, arbPkg::portL, 3, 3);
    addPacket(2, arbPkg::portN, 2, 2);
    addPacket(2, arbPkg::portE, 4, 4);
    addPacket(2, arbPkg::portW, 3, 3);
    addPacket(2, arbPkg::portS, 2, 2);
    addPacket(3, arbPkg::portL, 6, 3);  // Limit cuts L after 3 flits
    addPacket(3, arbPkg::portN, 2, 2);
    addPacket(4, arbPkg::portL, 3, 3);
    addPacket(4, arbPkg::portN, 2, 2);
    addPacket(4, arbPkg::portE, 4, 4);
    addPacket(4, arbPkg::portW, 3, 3);
    addPacket(4, arbPkg::portS, 2, 2);
    addPacket(5, arbPkg::portL, 1, 1);  // Fills the output register first
    addPacket(5, arbPkg::portE, 9, 9);
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    checkBit("outValid", outValid, 1'b0);
    for (int i = 0; i < arbPkg::numPorts; i++)
      checkBit($sformatf("Ready[%0d]", i), readyVec[i], 1'b1);
    for (int t = 2; t <= 5; t++)
      runTest(t);
    $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- all.f
hdl/flitPkg.sv
hdl/arbPkg.sv
hdl/inputFifo.sv
hdl/holdTimer.sv
hdl/switchArbiter.sv
hdl/outputStage.sv
hdl/flitSwitch.sv
sim/flitSwitch_props.sv
sim/flitSwitchTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = flitSwitchTb
FLIST     = all.f
OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)
LOG       = sim.log
SRCS      = $(shell cat $(FLIST))
PASSMSG   = PASS: all tests
FAILMSG   = FAIL: see errors above

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR) -o V$(TOP)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "$(FAILMSG)" $(LOG) || ! grep -q "$(PASSMSG)" $(LOG); \
	then exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
